// ==== files.f ====
rtl/tlb_pkg.sv
rtl/pte_fill_decode.sv
rtl/find_first_set.sv
rtl/tlb.sv
rtl/access_check.sv
rtl/mmu_translate_top.sv
tests/mmu_translate_props.sv
tests/tb_mmu_translate.sv

// ==== tests/tb_mmu_translate.sv ====
`timescale 1ns/1ns

module tb_mmu_translate;

   localparam int MAX_CYCLES = 400;

   logic          clk;
   logic          reset;
   logic          active;
   logic          clear;
   logic          req;
   logic [63:0]   va;
   logic [1:0]    priv;
   logic [1:0]    acc_type;
   logic          walk_valid;
   tlb_pkg::pte_u walk_pte;
   logic [1:0]    walk_level;
   logic [63:0]   walk_va;
   logic          result_valid;
   logic          miss;
   logic          fault;
   logic [63:0]   pa;
   logic          walk_error;
   logic [63:0]   tlb_hits;
   logic [63:0]   tlb_accesses;

   // expectation for what is being driven right now
   logic          cur_hit;
   logic          cur_fault;
   logic [63:0]   cur_pa;
   logic          cur_walk_legal;

   // two-deep queue of expected results
   logic          s1_valid;
   logic          s1_miss;
   logic          s1_fault;
   logic          s1_check_pa;
   logic [63:0]   s1_pa;
   logic          exp_valid;
   logic          exp_miss;
   logic          exp_fault;
   logic          exp_check_pa;
   logic [63:0]   exp_pa;
   logic          exp_walk_error;
   logic [63:0]   exp_hits;
   logic [63:0]   exp_accesses;

   // last legal fill
   logic          m_valid;
   tlb_pkg::pte_u m_pte;
   logic [1:0]    m_level;
   logic [63:0]   m_va;

   logic [127:0]  test_name;
   integer        seed;
   int            cycle_count = 0;

   mmu_translate_top #(.LG_N(2)) dut
   (
      .clk          (clk),
      .reset        (reset),
      .active       (active),
      .clear        (clear),
      .req          (req),
      .va           (va),
      .priv         (priv),
      .acc_type     (acc_type),
      .walk_valid   (walk_valid),
      .walk_pte     (walk_pte),
      .walk_level   (walk_level),
      .walk_va      (walk_va),
      .result_valid (result_valid),
      .miss         (miss),
      .fault        (fault),
      .pa           (pa),
      .walk_error   (walk_error),
      .tlb_hits     (tlb_hits),
      .tlb_accesses (tlb_accesses)
   );

   bind mmu_translate_top mmu_translate_props u_props
   (
      .clk            (clk),
      .reset          (reset),
      .result_valid   (result_valid),
      .miss           (miss),
      .fault          (fault),
      .pa             (pa),
      .walk_error     (walk_error),
      .tlb_hits       (tlb_hits),
      .tlb_accesses   (tlb_accesses),
      .exp_valid      (tb_mmu_translate.exp_valid),
      .exp_miss       (tb_mmu_translate.exp_miss),
      .exp_fault      (tb_mmu_translate.exp_fault),
      .exp_check_pa   (tb_mmu_translate.exp_check_pa),
      .exp_pa         (tb_mmu_translate.exp_pa),
      .exp_walk_error (tb_mmu_translate.exp_walk_error),
      .exp_hits       (tb_mmu_translate.exp_hits),
      .exp_accesses   (tb_mmu_translate.exp_accesses),
      .test_name      (tb_mmu_translate.test_name)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic tlb_pkg::pte_u make_pte(logic [43:0] ppn, logic v, logic r, logic w,
                                              logic x, logic u, logic d);
      tlb_pkg::pte_u p;
      p.raw   = 64'd0;
      p.f.ppn = ppn;
      p.f.v   = v;
      p.f.r   = r;
      p.f.w   = w;
      p.f.x   = x;
      p.f.u   = u;
      p.f.d   = d;
      return p;
   endfunction

   // leaf rules plus superpage alignment
   function automatic logic pte_is_legal(tlb_pkg::pte_u p, logic [1:0] level);
      logic aligned;
      case (level)
         tlb_pkg::PG_2M: aligned = (p.f.ppn[8:0] == '0);
         tlb_pkg::PG_1G: aligned = (p.f.ppn[17:0] == '0);
         default:        aligned = (level == tlb_pkg::PG_4K);
      endcase
      return p.f.v && (p.f.r || p.f.w || p.f.x) && !(p.f.w && !p.f.r) && aligned;
   endfunction

   function automatic logic page_hits(logic [63:0] addr);
      case (m_level)
         tlb_pkg::PG_1G: return m_valid && (addr[39:30] == m_va[39:30]);
         tlb_pkg::PG_2M: return m_valid && (addr[39:21] == m_va[39:21]);
         default:        return m_valid && (addr[39:12] == m_va[39:12]);
      endcase
   endfunction

   function automatic logic [63:0] expected_pa(logic [63:0] addr);
      logic [63:0] base;
      base = {8'd0, m_pte.f.ppn, 12'd0};
      case (m_level)
         tlb_pkg::PG_1G: return {base[63:30], addr[29:0]};
         tlb_pkg::PG_2M: return {base[63:21], addr[20:0]};
         default:        return {base[63:12], addr[11:0]};
      endcase
   endfunction

   function automatic logic access_faults(logic [1:0] p, logic [1:0] a);
      logic bad;
      bad = 1'b0;
      if (m_pte.f.u && p == tlb_pkg::PRIV_SUPER)
         bad = 1'b1;
      if (!m_pte.f.u && p == tlb_pkg::PRIV_USER)
         bad = 1'b1;
      if (a == tlb_pkg::ACC_LOAD && !m_pte.f.r)
         bad = 1'b1;
      if (a == tlb_pkg::ACC_STORE && !(m_pte.f.w && m_pte.f.d))
         bad = 1'b1;
      if (a == tlb_pkg::ACC_FETCH && !m_pte.f.x)
         bad = 1'b1;
      return bad;
   endfunction

   task automatic step();
      @(posedge clk);
      #10;
   endtask

   task automatic lookup(logic [63:0] addr, logic [1:0] p, logic [1:0] a);
      va        = addr;
      priv      = p;
      acc_type  = a;
      req       = 1'b1;
      cur_hit   = active ? page_hits(addr) : 1'b1;
      cur_fault = active && cur_hit && access_faults(p, a);
      cur_pa    = active ? expected_pa(addr) : addr;
      step();
   endtask

   // let the last two requests come out
   task automatic drain();
      req       = 1'b0;
      cur_hit   = 1'b0;
      cur_fault = 1'b0;
      step();
      step();
   endtask

   task automatic flush_tlb();
      req     = 1'b0;
      clear   = 1'b1;
      m_valid = 1'b0;
      step();
      clear = 1'b0;
   endtask

   // two cycles so the entry is written before the next lookup
   task automatic install(tlb_pkg::pte_u p, logic [1:0] level, logic [63:0] addr);
      walk_valid     = 1'b1;
      walk_pte       = p;
      walk_level     = level;
      walk_va        = addr;
      cur_walk_legal = pte_is_legal(p, level);
      if (cur_walk_legal)
      begin
         m_valid = 1'b1;
         m_pte   = p;
         m_level = level;
         m_va    = addr;
      end
      step();
      walk_valid = 1'b0;
      step();
   endtask

   task automatic page_test(logic [1:0] level, logic [63:0] base, logic [43:0] ppn,
                            logic [63:0] mask);
      logic [63:0] offset;
      flush_tlb();
      install(make_pte(ppn, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), level, base);
      repeat (3)
      begin
         offset = {32'd0, $random(seed)} & mask;
         lookup(base | offset, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      end
      // neighbouring page
      lookup(base ^ (mask + 64'd1), tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      drain();
   endtask

   task automatic perm_test(tlb_pkg::pte_u p);
      flush_tlb();
      install(p, tlb_pkg::PG_4K, 64'h0000_0003_0000_5000);
      for (int pv = 0; pv < 2; pv++)
      begin
         for (int ac = 0; ac < 3; ac++)
            lookup(64'h0000_0003_0000_5000 | 64'(ac * 8), 2'(pv), 2'(ac));
      end
      drain();
   endtask

   task automatic illegal_test(tlb_pkg::pte_u p, logic [1:0] level);
      flush_tlb();
      install(p, level, 64'h0000_0005_0020_0000);
      lookup(64'h0000_0005_0020_0010, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      drain();
   endtask

   // expected results follow the DUT pipeline
   always @(posedge clk)
   begin
      if (reset)
      begin
         s1_valid       <= 1'b0;
         s1_miss        <= 1'b0;
         s1_fault       <= 1'b0;
         s1_check_pa    <= 1'b0;
         s1_pa          <= '0;
         exp_valid      <= 1'b0;
         exp_miss       <= 1'b0;
         exp_fault      <= 1'b0;
         exp_check_pa   <= 1'b0;
         exp_pa         <= '0;
         exp_walk_error <= 1'b0;
         exp_hits       <= '0;
         exp_accesses   <= '0;
      end
      else
      begin
         s1_valid       <= req;
         s1_miss        <= req & ~cur_hit;
         s1_fault       <= req & cur_fault;
         s1_check_pa    <= req & cur_hit;
         s1_pa          <= cur_pa;
         exp_valid      <= s1_valid;
         exp_miss       <= s1_miss;
         exp_fault      <= s1_fault;
         exp_check_pa   <= s1_check_pa;
         exp_pa         <= s1_pa;
         exp_walk_error <= walk_valid & ~cur_walk_legal;
         if (req && active)
         begin
            exp_accesses <= exp_accesses + 64'd1;
            if (cur_hit)
               exp_hits <= exp_hits + 64'd1;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("RESULT: FAIL");
         $fatal(1, "simulation timed out");
      end
   end

   always @(posedge dut.u_props.failed)
   begin
      $display("RESULT: FAIL");
      $fatal(1, "assertion failed in test %0s", test_name);
   end

   initial
   begin
      seed           = 32;
      test_name      = "reset";
      reset          = 1'b1;
      active         = 1'b1;
      clear          = 1'b0;
      req            = 1'b0;
      va             = '0;
      priv           = tlb_pkg::PRIV_SUPER;
      acc_type       = tlb_pkg::ACC_LOAD;
      walk_valid     = 1'b0;
      walk_pte       = '0;
      walk_level     = tlb_pkg::PG_4K;
      walk_va        = '0;
      cur_hit        = 1'b0;
      cur_fault      = 1'b0;
      cur_pa         = '0;
      cur_walk_legal = 1'b1;
      m_valid        = 1'b0;
      m_pte          = '0;
      m_level        = tlb_pkg::PG_4K;
      m_va           = '0;
      repeat (3) @(posedge clk);
      #10;
      reset = 1'b0;

      test_name = "reset_miss";
      lookup(64'h0000_0000_0000_1000, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      lookup(64'h0000_0012_3456_7abc, tlb_pkg::PRIV_USER, tlb_pkg::ACC_STORE);
      lookup(64'h0000_0080_0000_0000, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_FETCH);
      drain();

      test_name = "fill_4k";
      page_test(tlb_pkg::PG_4K, 64'h0000_0012_3456_7000, 44'h0_0ABC_DE12, 64'hfff);
      test_name = "fill_2m";
      page_test(tlb_pkg::PG_2M, 64'h0000_0021_4060_0000, 44'h0_0001_2600, 64'h1f_ffff);
      test_name = "fill_1g";
      page_test(tlb_pkg::PG_1G, 64'h0000_0047_8000_0000, 44'h0_0034_0000, 64'h3fff_ffff);

      // args are ppn, v, r, w, x, u, d
      test_name = "fault_rules";
      perm_test(make_pte(44'h00abc, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1));
      perm_test(make_pte(44'h00abd, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
      perm_test(make_pte(44'h00abe, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
      perm_test(make_pte(44'h00abf, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));

      test_name = "illegal_pte";
      illegal_test(make_pte(44'h00123, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1), tlb_pkg::PG_4K);
      illegal_test(make_pte(44'h00123, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1), tlb_pkg::PG_4K);
      illegal_test(make_pte(44'h00123, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), tlb_pkg::PG_4K);
      illegal_test(make_pte(44'h00201, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1), tlb_pkg::PG_2M);
      illegal_test(make_pte(44'h40100, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1), tlb_pkg::PG_1G);

      test_name = "bare_mode";
      active = 1'b0;
      lookup(64'h0000_0003_0000_5000, tlb_pkg::PRIV_USER, tlb_pkg::ACC_STORE);
      lookup(64'hfedc_ba98_7654_3210, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_FETCH);
      lookup(64'h0000_0012_3456_7abc, tlb_pkg::PRIV_USER, tlb_pkg::ACC_LOAD);
      drain();
      active = 1'b1;

      test_name = "clear_miss";
      flush_tlb();
      install(make_pte(44'h00777, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0), tlb_pkg::PG_4K,
              64'h0000_0009_0000_3000);
      lookup(64'h0000_0009_0000_3010, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      lookup(64'h0000_0009_0000_3ff8, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      drain();
      flush_tlb();
      lookup(64'h0000_0009_0000_3010, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      lookup(64'h0000_0009_0000_3ff8, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_LOAD);
      drain();

      // hits and misses interleaved with mixed access types
      test_name = "back_to_back";
      flush_tlb();
      install(make_pte(44'h00555, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), tlb_pkg::PG_4K,
              64'h0000_000a_0000_1000);
      for (int i = 0; i < 8; i++)
      begin
         if (i % 2 == 0)
            lookup(64'h0000_000a_0000_1000 | 64'(i * 16), tlb_pkg::PRIV_SUPER, 2'(i % 3));
         else
            lookup(64'h0000_000b_0000_1000 | 64'(i * 16), tlb_pkg::PRIV_SUPER, 2'(i % 3));
      end
      // mode changes while earlier requests are still in flight
      lookup(64'h0000_000a_0000_1040, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_FETCH);
      active = 1'b0;
      lookup(64'h0000_000a_0000_1040, tlb_pkg::PRIV_SUPER, tlb_pkg::ACC_FETCH);
      active = 1'b1;
      lookup(64'h0000_000a_0000_1040, tlb_pkg::PRIV_USER, tlb_pkg::ACC_LOAD);
      drain();

      step();
      if (dut.u_props.failed)
      begin
         $display("RESULT: FAIL");
         $fatal(1, "a check failed during the run");
      end
      else
      begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

// ==== tests/mmu_translate_props.sv ====
`timescale 1ns/1ns

module mmu_translate_props
(
   input logic         clk,
   input logic         reset,
   input logic         result_valid,
   input logic         miss,
   input logic         fault,
   input logic [63:0]  pa,
   input logic         walk_error,
   input logic [63:0]  tlb_hits,
   input logic [63:0]  tlb_accesses,
   input logic         exp_valid,
   input logic         exp_miss,
   input logic         exp_fault,
   input logic         exp_check_pa,
   input logic [63:0]  exp_pa,
   input logic         exp_walk_error,
   input logic [63:0]  exp_hits,
   input logic [63:0]  exp_accesses,
   input logic [127:0] test_name
);

   // raised by any failing assertion, watched by the testbench
   logic failed = 1'b0;

   // result must land exactly two edges after the request
   a_valid: assert property (@(posedge clk) disable iff (reset) result_valid == exp_valid)
      else
      begin
         $error("Fail %0s: result_valid expected %0b actual %0b",
                test_name, $sampled(exp_valid), $sampled(result_valid));
         failed = 1'b1;
      end

   a_miss: assert property (@(posedge clk) disable iff (reset)
                            result_valid |-> miss == exp_miss)
      else
      begin
         $error("Fail %0s: miss expected %0b actual %0b",
                test_name, $sampled(exp_miss), $sampled(miss));
         failed = 1'b1;
      end

   a_fault: assert property (@(posedge clk) disable iff (reset)
                             result_valid |-> fault == exp_fault)
      else
      begin
         $error("Fail %0s: fault expected %0b actual %0b",
                test_name, $sampled(exp_fault), $sampled(fault));
         failed = 1'b1;
      end

   // pa only means something on a hit
   a_pa: assert property (@(posedge clk) disable iff (reset)
                          result_valid && exp_check_pa |-> pa == exp_pa)
      else
      begin
         $error("Fail %0s: pa expected %h actual %h",
                test_name, $sampled(exp_pa), $sampled(pa));
         failed = 1'b1;
      end

   a_walk_error: assert property (@(posedge clk) disable iff (reset)
                                  walk_error == exp_walk_error)
      else
      begin
         $error("Fail %0s: walk_error expected %0b actual %0b",
                test_name, $sampled(exp_walk_error), $sampled(walk_error));
         failed = 1'b1;
      end

   a_counters: assert property (@(posedge clk) disable iff (reset)
                                tlb_hits == exp_hits && tlb_accesses == exp_accesses)
      else
      begin
         $error("Fail %0s: hits/accesses expected %0d/%0d actual %0d/%0d", test_name,
                $sampled(exp_hits), $sampled(exp_accesses),
                $sampled(tlb_hits), $sampled(tlb_accesses));
         failed = 1'b1;
      end

endmodule

// ==== rtl/mmu_translate_top.sv ====
`timescale 1ns/1ns

module mmu_translate_top
#(
   parameter int LG_N = 2
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          active,
   input  logic          clear,
   input  logic          req,
   input  logic [63:0]   va,
   input  logic [1:0]    priv,
   input  logic [1:0]    acc_type,
   input  logic          walk_valid,
   input  tlb_pkg::pte_u walk_pte,
   input  logic [1:0]    walk_level,
   input  logic [63:0]   walk_va,
   output logic          result_valid,
   output logic          miss,
   output logic          fault,
   output logic [63:0]   pa,
   output logic          walk_error,
   output logic [63:0]   tlb_hits,
   output logic [63:0]   tlb_accesses
);

   // fill path
   logic        fill;
   logic [63:0] fill_va;
   logic [51:0] fill_ppn;
   logic [1:0]  fill_pgsize;
   logic        fill_readable;
   logic        fill_writable;
   logic        fill_executable;
   logic        fill_user;
   logic        fill_dirty;

   // lookup stage
   logic        lk_valid;
   logic        lk_hit;
   logic [63:0] lk_pa;
   logic        lk_readable;
   logic        lk_writable;
   logic        lk_executable;
   logic        lk_user;
   logic        lk_dirty;
   logic [1:0]  lk_priv;
   logic [1:0]  lk_acc_type;

   pte_fill_decode u_decode
   (
      .clk             (clk),
      .reset           (reset),
      .walk_valid      (walk_valid),
      .walk_pte        (walk_pte),
      .walk_level      (walk_level),
      .walk_va         (walk_va),
      .fill            (fill),
      .fill_va         (fill_va),
      .fill_ppn        (fill_ppn),
      .fill_pgsize     (fill_pgsize),
      .fill_readable   (fill_readable),
      .fill_writable   (fill_writable),
      .fill_executable (fill_executable),
      .fill_user       (fill_user),
      .fill_dirty      (fill_dirty),
      .walk_error      (walk_error)
   );

   tlb #(.LG_N(LG_N)) u_tlb
   (
      .clk             (clk),
      .reset           (reset),
      .clear           (clear),
      .active          (active),
      .req             (req),
      .va              (va),
      .priv            (priv),
      .acc_type        (acc_type),
      .fill            (fill),
      .fill_va         (fill_va),
      .fill_ppn        (fill_ppn),
      .fill_pgsize     (fill_pgsize),
      .fill_readable   (fill_readable),
      .fill_writable   (fill_writable),
      .fill_executable (fill_executable),
      .fill_user       (fill_user),
      .fill_dirty      (fill_dirty),
      .lk_valid        (lk_valid),
      .lk_hit          (lk_hit),
      .lk_pa           (lk_pa),
      .lk_readable     (lk_readable),
      .lk_writable     (lk_writable),
      .lk_executable   (lk_executable),
      .lk_user         (lk_user),
      .lk_dirty        (lk_dirty),
      .lk_priv         (lk_priv),
      .lk_acc_type     (lk_acc_type),
      .tlb_hits        (tlb_hits),
      .tlb_accesses    (tlb_accesses)
   );

   access_check u_check
   (
      .clk             (clk),
      .reset           (reset),
      .active          (active),
      .lk_valid        (lk_valid),
      .lk_hit          (lk_hit),
      .lk_pa           (lk_pa),
      .lk_readable     (lk_readable),
      .lk_writable     (lk_writable),
      .lk_executable   (lk_executable),
      .lk_user         (lk_user),
      .lk_dirty        (lk_dirty),
      .lk_priv         (lk_priv),
      .lk_acc_type     (lk_acc_type),
      .result_valid    (result_valid),
      .miss            (miss),
      .fault           (fault),
      .pa              (pa)
   );

endmodule

// ==== rtl/access_check.sv ====
`timescale 1ns/1ns

module access_check
(
   input  logic        clk,
   input  logic        reset,
   input  logic        active,
   input  logic        lk_valid,
   input  logic        lk_hit,
   input  logic [63:0] lk_pa,
   input  logic        lk_readable,
   input  logic        lk_writable,
   input  logic        lk_executable,
   input  logic        lk_user,
   input  logic        lk_dirty,
   input  logic [1:0]  lk_priv,
   input  logic [1:0]  lk_acc_type,
   output logic        result_valid,
   output logic        miss,
   output logic        fault,
   output logic [63:0] pa
);

   logic priv_bad;
   logic perm_bad;
   logic fault_n;
   logic r_active;

   // mode of the request now in the lookup stage
   always_ff @(posedge clk)
   begin
      r_active <= active;
   end

   // user pages for user mode only, and the reverse
   assign priv_bad = lk_user ? (lk_priv == tlb_pkg::PRIV_SUPER)
                             : (lk_priv == tlb_pkg::PRIV_USER);

   always_comb
   begin
      case (lk_acc_type)
         tlb_pkg::ACC_LOAD:  perm_bad = ~lk_readable;
         // stores also need the dirty bit, since A/D updates are not done here
         tlb_pkg::ACC_STORE: perm_bad = ~lk_writable | ~lk_dirty;
         tlb_pkg::ACC_FETCH: perm_bad = ~lk_executable;
         default:            perm_bad = 1'b0;
      endcase
   end

   // only a translated hit can fault
   assign fault_n = lk_valid & lk_hit & r_active & (priv_bad | perm_bad);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         result_valid <= 1'b0;
         miss         <= 1'b0;
         fault        <= 1'b0;
      end
      else
      begin
         result_valid <= lk_valid;
         miss         <= lk_valid & ~lk_hit;
         fault        <= fault_n;
      end
   end

   always_ff @(posedge clk)
   begin
      pa <= lk_pa;
   end

endmodule

// ==== rtl/tlb.sv ====
`timescale 1ns/1ns

module tlb
#(
   parameter int LG_N = 2
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        clear,
   input  logic        active,
   input  logic        req,
   input  logic [63:0] va,
   input  logic [1:0]  priv,
   input  logic [1:0]  acc_type,
   input  logic        fill,
   input  logic [63:0] fill_va,
   input  logic [51:0] fill_ppn,
   input  logic [1:0]  fill_pgsize,
   input  logic        fill_readable,
   input  logic        fill_writable,
   input  logic        fill_executable,
   input  logic        fill_user,
   input  logic        fill_dirty,
   output logic        lk_valid,
   output logic        lk_hit,
   output logic [63:0] lk_pa,
   output logic        lk_readable,
   output logic        lk_writable,
   output logic        lk_executable,
   output logic        lk_user,
   output logic        lk_dirty,
   output logic [1:0]  lk_priv,
   output logic [1:0]  lk_acc_type,
   output logic [63:0] tlb_hits,
   output logic [63:0] tlb_accesses
);

   localparam int N = 1 << LG_N;

   logic [N-1:0]                 r_valid;
   logic [N-1:0]                 r_readable;
   logic [N-1:0]                 r_writable;
   logic [N-1:0]                 r_executable;
   logic [N-1:0]                 r_user;
   logic [N-1:0]                 r_dirty;
   logic [1:0]                   r_pgsize [N];
   logic [tlb_pkg::VA_TAG_W-1:0] r_tag [N];
   logic [tlb_pkg::PPN_W-1:0]    r_ppn [N];

   logic [N-1:0]    w_hits;
   logic [LG_N:0]   w_idx;
   logic [LG_N-1:0] sel;
   logic            any_hit;
   logic [63:0]     pa_sel;
   logic [15:0]     r_lfsr;
   logic [LG_N-1:0] victim;

   // tag compare at each entry's own page size
   for (genvar i = 0; i < N; i++)
   begin : g_match
      logic m4k, m2m, m1g;
      assign m4k = (r_pgsize[i] == tlb_pkg::PG_4K) & (r_tag[i] == va[39:12]);
      assign m2m = (r_pgsize[i] == tlb_pkg::PG_2M) & (r_tag[i][27:9] == va[39:21]);
      assign m1g = (r_pgsize[i] == tlb_pkg::PG_1G) & (r_tag[i][27:18] == va[39:30]);
      assign w_hits[i] = r_valid[i] & (m4k | m2m | m1g);
   end

   find_first_set #(.LG_N(LG_N)) u_ffs
   (
      .in (w_hits),
      .y  (w_idx)
   );

   assign sel     = w_idx[LG_N-1:0];
   assign any_hit = w_idx[LG_N];

   // splice page offset from va according to page size
   always_comb
   begin
      case (r_pgsize[sel])
         tlb_pkg::PG_1G: pa_sel = {r_ppn[sel][51:18], va[29:0]};
         tlb_pkg::PG_2M: pa_sel = {r_ppn[sel][51:9], va[20:0]};
         default:        pa_sel = {r_ppn[sel], va[11:0]};
      endcase
   end

   // victim choice, free running
   always_ff @(posedge clk)
   begin
      if (reset)
         r_lfsr <= 16'd1;
      else
         r_lfsr <= {r_lfsr[14:0], r_lfsr[15] ^ r_lfsr[13] ^ r_lfsr[12] ^ r_lfsr[10]};
   end

   assign victim = r_lfsr[LG_N:1];

   // clear wins over a fill in the same cycle
   always_ff @(posedge clk)
   begin
      if (reset || clear)
         r_valid <= '0;
      else if (fill)
         r_valid[victim] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (fill)
      begin
         r_tag[victim]        <= fill_va[39:12];
         r_ppn[victim]        <= fill_ppn;
         r_pgsize[victim]     <= fill_pgsize;
         r_readable[victim]   <= fill_readable;
         r_writable[victim]   <= fill_writable;
         r_executable[victim] <= fill_executable;
         r_user[victim]       <= fill_user;
         r_dirty[victim]      <= fill_dirty;
      end
   end

   // translated requests only
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tlb_hits     <= '0;
         tlb_accesses <= '0;
      end
      else if (active & req)
      begin
         tlb_accesses <= tlb_accesses + 64'd1;
         if (any_hit)
            tlb_hits <= tlb_hits + 64'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         lk_valid <= 1'b0;
      else
         lk_valid <= req;
   end

   // lookup stage, bare mode passes va through as a hit
   always_ff @(posedge clk)
   begin
      lk_hit        <= active ? (req & any_hit) : 1'b1;
      lk_pa         <= active ? pa_sel : va;
      lk_readable   <= r_readable[sel];
      lk_writable   <= r_writable[sel];
      lk_executable <= r_executable[sel];
      lk_user       <= r_user[sel];
      lk_dirty      <= r_dirty[sel];
      lk_priv       <= priv;
      lk_acc_type   <= acc_type;
   end

endmodule

// ==== rtl/find_first_set.sv ====
`timescale 1ns/1ns

module find_first_set
#(
   parameter int LG_N = 2
)
(
   input  logic [(1<<LG_N)-1:0] in,
   output logic [LG_N:0]        y
);

   localparam int N = 1 << LG_N;

   // scan from the top so the lowest set bit wins
   always_comb
   begin
      y = '0;
      for (int i = N - 1; i >= 0; i--)
      begin
         if (in[i])
         begin
            y[LG_N-1:0] = LG_N'(i);
            y[LG_N]     = 1'b1;
         end
      end
   end

endmodule

// ==== rtl/pte_fill_decode.sv ====
`timescale 1ns/1ns

module pte_fill_decode
(
   input  logic              clk,
   input  logic              reset,
   input  logic              walk_valid,
   input  tlb_pkg::pte_u     walk_pte,
   input  logic [1:0]        walk_level,
   input  logic [63:0]       walk_va,
   output logic              fill,
   output logic [63:0]       fill_va,
   output logic [51:0]       fill_ppn,
   output logic [1:0]        fill_pgsize,
   output logic              fill_readable,
   output logic              fill_writable,
   output logic              fill_executable,
   output logic              fill_user,
   output logic              fill_dirty,
   output logic              walk_error
);

   logic has_perm;
   logic perm_ok;
   logic aligned;
   logic legal;

   // a leaf needs some permission, and write only together with read
   assign has_perm = walk_pte.f.r | walk_pte.f.w | walk_pte.f.x;
   assign perm_ok  = has_perm & ~(walk_pte.f.w & ~walk_pte.f.r);

   // superpages must have their low ppn bits clear
   always_comb
   begin
      case (walk_level)
         tlb_pkg::PG_4K: aligned = 1'b1;
         tlb_pkg::PG_2M: aligned = (walk_pte.f.ppn[8:0] == 9'd0);
         tlb_pkg::PG_1G: aligned = (walk_pte.f.ppn[17:0] == 18'd0);
         default:        aligned = 1'b0;
      endcase
   end

   assign legal = walk_pte.f.v & perm_ok & aligned;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fill       <= 1'b0;
         walk_error <= 1'b0;
      end
      else
      begin
         fill       <= walk_valid & legal;
         walk_error <= walk_valid & ~legal;
      end
   end

   // held alongside the fill strobe
   always_ff @(posedge clk)
   begin
      fill_va         <= walk_va;
      fill_ppn        <= {8'd0, walk_pte.f.ppn};
      fill_pgsize     <= walk_level;
      fill_readable   <= walk_pte.f.r;
      fill_writable   <= walk_pte.f.w;
      fill_executable <= walk_pte.f.x;
      fill_user       <= walk_pte.f.u;
      fill_dirty      <= walk_pte.f.d;
   end

endmodule

// ==== rtl/tlb_pkg.sv ====
package tlb_pkg;

   // page table entry, read either as one word or as its fields
   typedef union packed
   {
      logic [63:0] raw;
      struct packed
      {
         logic [9:0]  reserved_hi;
         logic [43:0] ppn;
         logic [1:0]  rsw;
         logic        d;
         logic        a;
         logic        g;
         logic        u;
         logic        x;
         logic        w;
         logic        r;
         logic        v;
      } f;
   } pte_u;

   // page size codes, shared by walk level and stored size
   localparam logic [1:0] PG_1G = 2'd0;
   localparam logic [1:0] PG_2M = 2'd1;
   localparam logic [1:0] PG_4K = 2'd2;

   // access types
   localparam logic [1:0] ACC_LOAD  = 2'd0;
   localparam logic [1:0] ACC_STORE = 2'd1;
   localparam logic [1:0] ACC_FETCH = 2'd2;

   // privilege levels
   localparam logic [1:0] PRIV_USER  = 2'd0;
   localparam logic [1:0] PRIV_SUPER = 2'd1;

   // va bits 39 down to 12
   localparam int VA_TAG_W = 28;
   localparam int PPN_W    = 52;

endpackage
